/* isaPkg.sv */
package isaPkg;

    // Architectural data word
    typedef logic [31:0] wordT;

    // Main-bank register index
    typedef logic [3:0] regIdxT;

    // Immediate field, zero-extended on use
    typedef logic [15:0] immT;

    // Opcode space
    // Plain ALU ops run in one cycle, OP_M* ops expand into microcode
    typedef enum logic [3:0] {
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_AND   = 4'd2,
        OP_OR    = 4'd3,
        OP_XOR   = 4'd4,
        OP_LDI   = 4'd5,
        OP_MQUAD = 4'd6,
        OP_MTRI  = 4'd7
    } opT;

    // Instruction word as delivered with instrValid
    typedef struct packed {
        opT     op;
        regIdxT rd;
        regIdxT rs1;
        regIdxT rs2;
        immT    imm;
    } instrT;

    // Size of each register bank
    localparam int NUM_REGS = 16;

    // Microcode scratch register, only ever written in the shadow bank
    localparam regIdxT SCRATCH_REG = 4'd15;

endpackage

/* ucodePkg.sv */
package ucodePkg;

    // Control FSM states
    // S_ENTER copies main bank into shadow bank
    // S_STEP runs one micro-op per cycle
    typedef enum logic [1:0] {
        S_IDLE  = 2'd0,
        S_ENTER = 2'd1,
        S_STEP  = 2'd2
    } ctrlStateT;

    // Operand selectors, resolved against the latched macro instruction
    typedef enum logic [1:0] {
        SEL_RD  = 2'd0,
        SEL_RS1 = 2'd1,
        SEL_RS2 = 2'd2,
        SEL_SCR = 2'd3
    } srcSelT;

    // Step index into a microcode sequence
    typedef logic [1:0] stepT;

    // One micro-op
    // last marks the final step, which also writes the main bank
    typedef struct packed {
        isaPkg::opT aluOp;
        srcSelT     dst;
        srcSelT     srcA;
        srcSelT     srcB;
        logic       last;
    } uopT;

    // Longest sequence the step index can address
    localparam int MAX_STEPS = 4;

endpackage

/* regFile.sv */
`timescale 1ns/100ps

module regFile (
    input  logic           clk,
    input  logic           rst,
    input  logic           ucodeMode,
    input  logic           bankCopy,
    input  logic           writeMain,
    input  logic           writeShadow,
    input  isaPkg::regIdxT wrAddr,
    input  isaPkg::regIdxT rdAddrA,
    input  isaPkg::regIdxT rdAddrB,
    input  isaPkg::wordT   wrData,
    input  isaPkg::regIdxT readAddr,
    output isaPkg::wordT   rdDataA,
    output isaPkg::wordT   rdDataB,
    output isaPkg::wordT   readData
);

    // Architectural registers
    isaPkg::wordT mainBank [isaPkg::NUM_REGS];

    // Shadow copy used while microcode runs
    isaPkg::wordT shadowBank [isaPkg::NUM_REGS];

    // Main bank
    // Only plain ops and the last micro-op write here
    always_ff @(posedge clk) begin
        if (rst) begin
            mainBank <= '{default: '0};
        end else if (writeMain) begin
            mainBank[wrAddr] <= wrData;
        end
    end

    // Shadow bank
    // Whole-bank copy in one edge on macro entry
    always_ff @(posedge clk) begin
        if (rst) begin
            shadowBank <= '{default: '0};
        end else if (bankCopy) begin
            shadowBank <= mainBank;
        end else if (writeShadow) begin
            shadowBank[wrAddr] <= wrData;
        end
    end

    // Operand reads follow the active bank
    assign rdDataA = ucodeMode ? shadowBank[rdAddrA] : mainBank[rdAddrA];
    assign rdDataB = ucodeMode ? shadowBank[rdAddrB] : mainBank[rdAddrB];

    // Observation port, always architectural state
    assign readData = mainBank[readAddr];

    // Copy must not race a write, otherwise the snapshot is stale or partial
    copyNoWrite: assert property (
        @(posedge clk) disable iff (rst)
        bankCopy |-> !(writeMain || writeShadow)
    ) else $error("regFile: bankCopy together with a write strobe");

endmodule

/* alu.sv */
`timescale 1ns/100ps

module alu (
    input  isaPkg::opT   aluOp,
    input  isaPkg::wordT a,
    input  isaPkg::wordT b,
    output isaPkg::wordT y
);

    always_comb begin
        case (aluOp)
            isaPkg::OP_ADD: y = a + b;
            isaPkg::OP_SUB: y = a - b;
            isaPkg::OP_AND: y = a & b;
            isaPkg::OP_OR:  y = a | b;
            isaPkg::OP_XOR: y = a ^ b;
            // Immediate load, b already carries the zero-extended imm
            isaPkg::OP_LDI: y = b;
            // Macro opcodes are expanded by the control and never land here
            default:        y = '0;
        endcase
    end

    // Control must replace a macro opcode by its micro-op ALU codes
    noMacroOp: assert final (
        $isunknown(aluOp) ||
        !(aluOp inside {isaPkg::OP_MQUAD, isaPkg::OP_MTRI})
    ) else $error("alu: macro opcode %0d reached the ALU", aluOp);

endmodule

/* ucodeRom.sv */
`timescale 1ns/100ps

module ucodeRom (
    input  isaPkg::opT     macroOp,
    input  ucodePkg::stepT step,
    output ucodePkg::uopT  uop
);

    // Builds one table entry
    function automatic ucodePkg::uopT mkUop(
        input isaPkg::opT       op,
        input ucodePkg::srcSelT dst,
        input ucodePkg::srcSelT srcA,
        input ucodePkg::srcSelT srcB,
        input logic             last
    );
        ucodePkg::uopT u;
        u.aluOp = op;
        u.dst   = dst;
        u.srcA  = srcA;
        u.srcB  = srcB;
        u.last  = last;
        return u;
    endfunction

    always_comb begin
        // Unused slots end the sequence at once
        uop = mkUop(isaPkg::OP_OR, ucodePkg::SEL_RD, ucodePkg::SEL_SCR,
                    ucodePkg::SEL_SCR, 1'b1);
        case (macroOp)
            // rd = 4 * rs1
            isaPkg::OP_MQUAD: begin
                case (step)
                    2'd0: uop = mkUop(isaPkg::OP_ADD, ucodePkg::SEL_SCR,
                                      ucodePkg::SEL_RS1, ucodePkg::SEL_RS1, 1'b0);
                    2'd1: uop = mkUop(isaPkg::OP_ADD, ucodePkg::SEL_RD,
                                      ucodePkg::SEL_SCR, ucodePkg::SEL_SCR, 1'b1);
                    default: ;
                endcase
            end
            // rd = rs1 + 2 * rs2
            isaPkg::OP_MTRI: begin
                case (step)
                    2'd0: uop = mkUop(isaPkg::OP_ADD, ucodePkg::SEL_SCR,
                                      ucodePkg::SEL_RS2, ucodePkg::SEL_RS2, 1'b0);
                    2'd1: uop = mkUop(isaPkg::OP_ADD, ucodePkg::SEL_SCR,
                                      ucodePkg::SEL_SCR, ucodePkg::SEL_RS1, 1'b0);
                    // Move scratch into rd
                    2'd2: uop = mkUop(isaPkg::OP_OR, ucodePkg::SEL_RD,
                                      ucodePkg::SEL_SCR, ucodePkg::SEL_SCR, 1'b1);
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

/* coreCtrl.sv */
`timescale 1ns/100ps

module coreCtrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             instrValid,
    input  isaPkg::instrT    instr,
    input  ucodePkg::uopT    uop,
    input  isaPkg::wordT     aluY,
    output logic             busy,
    output logic             done,
    output isaPkg::wordT     result,
    output logic             ucodeMode,
    output logic             bankCopy,
    output logic             writeMain,
    output logic             writeShadow,
    output isaPkg::regIdxT   wrAddr,
    output isaPkg::regIdxT   rdAddrA,
    output isaPkg::regIdxT   rdAddrB,
    output isaPkg::opT       aluOp,
    output isaPkg::wordT     immWord,
    output logic             useImm,
    output isaPkg::opT       macroOp,
    output ucodePkg::stepT   step
);

    ucodePkg::ctrlStateT state;
    ucodePkg::stepT      stepQ;
    isaPkg::instrT       macroInstr;
    logic                accept;
    logic                isMacro;
    logic                lastStep;

    // Selector to register index, scratch is fixed
    function automatic isaPkg::regIdxT selIdx(
        input ucodePkg::srcSelT sel,
        input isaPkg::instrT    ins
    );
        isaPkg::regIdxT idx;
        case (sel)
            ucodePkg::SEL_RS1: idx = ins.rs1;
            ucodePkg::SEL_RS2: idx = ins.rs2;
            ucodePkg::SEL_SCR: idx = isaPkg::SCRATCH_REG;
            default:           idx = ins.rd;
        endcase
        return idx;
    endfunction

    // Strobes while busy are dropped here
    assign accept   = instrValid && (state == ucodePkg::S_IDLE);
    assign isMacro  = instr.op inside {isaPkg::OP_MQUAD, isaPkg::OP_MTRI};
    assign lastStep = (state == ucodePkg::S_STEP) && uop.last;

    assign busy      = (state != ucodePkg::S_IDLE);
    assign bankCopy  = (state == ucodePkg::S_ENTER);
    assign ucodeMode = (state == ucodePkg::S_STEP);

    // Plain op writes main at the accepting edge
    assign writeMain   = (accept && !isMacro) || lastStep;
    assign writeShadow = (state == ucodePkg::S_STEP);

    assign macroOp = macroInstr.op;
    assign step    = stepQ;
    assign immWord = isaPkg::wordT'(instr.imm);

    // Operand steering, ROM driven in microcode, else straight decode
    always_comb begin
        if (state == ucodePkg::S_STEP) begin
            wrAddr  = selIdx(uop.dst, macroInstr);
            rdAddrA = selIdx(uop.srcA, macroInstr);
            rdAddrB = selIdx(uop.srcB, macroInstr);
            aluOp   = uop.aluOp;
            useImm  = 1'b0;
        end else begin
            wrAddr  = instr.rd;
            rdAddrA = instr.rs1;
            rdAddrB = instr.rs2;
            // Keep macro codes away from the ALU
            aluOp   = isMacro ? isaPkg::OP_ADD : instr.op;
            useImm  = (instr.op == isaPkg::OP_LDI);
        end
    end

    // Control FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ucodePkg::S_IDLE;
            stepQ <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ucodePkg::S_IDLE: begin
                    if (accept && isMacro) begin
                        stepQ <= '0;
                        state <= ucodePkg::S_ENTER;
                    end else if (accept) begin
                        done <= 1'b1;
                    end
                end
                ucodePkg::S_ENTER: state <= ucodePkg::S_STEP;
                ucodePkg::S_STEP: begin
                    if (uop.last) begin
                        state <= ucodePkg::S_IDLE;
                        done  <= 1'b1;
                    end else begin
                        stepQ <= stepQ + 1'b1;
                    end
                end
                default: state <= ucodePkg::S_IDLE;
            endcase
        end
    end

    // Macro instruction held for the whole sequence
    always_ff @(posedge clk) begin
        if (accept && isMacro) begin
            macroInstr <= instr;
        end
    end

    // Result captured with every main-bank write
    always_ff @(posedge clk) begin
        if (writeMain) begin
            result <= aluY;
        end
    end

    // No back-pressure, so a strobe while busy is a protocol error
    noStrobeWhileBusy: assert property (
        @(posedge clk) disable iff (rst)
        busy |-> !instrValid
    ) else $error("coreCtrl: instrValid while busy");

    // Every ROM sequence ends before the step index wraps
    stepInRange: assert property (
        @(posedge clk) disable iff (rst)
        (state == ucodePkg::S_STEP &&
         stepQ == ucodePkg::stepT'(ucodePkg::MAX_STEPS - 1)) |-> uop.last
    ) else $error("coreCtrl: microcode step reached MAX_STEPS");

endmodule

/* execCore.sv */
`timescale 1ns/100ps

module execCore (
    input  logic           clk,
    input  logic           rst,
    input  logic           instrValid,
    input  isaPkg::instrT  instr,
    input  isaPkg::regIdxT readAddr,
    output logic           busy,
    output logic           done,
    output isaPkg::wordT   result,
    output isaPkg::wordT   readData
);

    // Control to register file
    logic           ucodeMode;
    logic           bankCopy;
    logic           writeMain;
    logic           writeShadow;
    isaPkg::regIdxT wrAddr;
    isaPkg::regIdxT rdAddrA;
    isaPkg::regIdxT rdAddrB;

    // Datapath
    isaPkg::wordT   rdDataA;
    isaPkg::wordT   rdDataB;
    isaPkg::wordT   immWord;
    isaPkg::wordT   aluB;
    isaPkg::wordT   aluY;
    isaPkg::opT     aluOp;
    logic           useImm;

    // Microcode lookup
    isaPkg::opT     macroOp;
    ucodePkg::stepT step;
    ucodePkg::uopT  uop;

    coreCtrl ctrl (
        .clk         (clk),
        .rst         (rst),
        .instrValid  (instrValid),
        .instr       (instr),
        .uop         (uop),
        .aluY        (aluY),
        .busy        (busy),
        .done        (done),
        .result      (result),
        .ucodeMode   (ucodeMode),
        .bankCopy    (bankCopy),
        .writeMain   (writeMain),
        .writeShadow (writeShadow),
        .wrAddr      (wrAddr),
        .rdAddrA     (rdAddrA),
        .rdAddrB     (rdAddrB),
        .aluOp       (aluOp),
        .immWord     (immWord),
        .useImm      (useImm),
        .macroOp     (macroOp),
        .step        (step)
    );

    regFile regs (
        .clk         (clk),
        .rst         (rst),
        .ucodeMode   (ucodeMode),
        .bankCopy    (bankCopy),
        .writeMain   (writeMain),
        .writeShadow (writeShadow),
        .wrAddr      (wrAddr),
        .rdAddrA     (rdAddrA),
        .rdAddrB     (rdAddrB),
        .wrData      (aluY),
        .readAddr    (readAddr),
        .rdDataA     (rdDataA),
        .rdDataB     (rdDataB),
        .readData    (readData)
    );

    // Immediate replaces the second register operand for OP_LDI
    assign aluB = useImm ? immWord : rdDataB;

    alu aluUnit (
        .aluOp (aluOp),
        .a     (rdDataA),
        .b     (aluB),
        .y     (aluY)
    );

    ucodeRom rom (
        .macroOp (macroOp),
        .step    (step),
        .uop     (uop)
    );

endmodule

/* tbExecCore.sv */
`timescale 1ns/100ps

module tbExecCore;

    // Whole run stays well under 600 cycles, limit leaves wide margin
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int DONE_WAIT      = 8;
    localparam int PLAIN_LAT      = 1;
    localparam int QUAD_LAT       = 4;
    localparam int TRI_LAT        = 5;

    logic           clk;
    logic           rst;
    logic           instrValid;
    isaPkg::instrT  instr;
    isaPkg::regIdxT readAddr;
    logic           busy;
    logic           done;
    isaPkg::wordT   result;
    isaPkg::wordT   readData;

    // Expected main-bank contents
    isaPkg::wordT   model [isaPkg::NUM_REGS];
    logic [31:0]    rngState;
    int             valueErrors = 0;
    int             protocolErrors = 0;
    int             cycleCount = 0;

    execCore UUT (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .readAddr   (readAddr),
        .busy       (busy),
        .done       (done),
        .result     (result),
        .readData   (readData)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, tests did not finish", cycleCount);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Xorshift32 generator
    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    // Any register but the microcode scratch
    function automatic isaPkg::regIdxT pickReg();
        logic [31:0] r;
        r = nextRand();
        return isaPkg::regIdxT'(r % 15);
    endfunction

    function automatic isaPkg::instrT makeInstr(
        input isaPkg::opT     op,
        input isaPkg::regIdxT rd,
        input isaPkg::regIdxT rs1,
        input isaPkg::regIdxT rs2,
        input isaPkg::immT    imm
    );
        isaPkg::instrT ins;
        ins.op  = op;
        ins.rd  = rd;
        ins.rs1 = rs1;
        ins.rs2 = rs2;
        ins.imm = imm;
        return ins;
    endfunction

    // Reference arithmetic of the plain ops
    function automatic isaPkg::wordT expectedAlu(
        input isaPkg::opT   op,
        input isaPkg::wordT a,
        input isaPkg::wordT b
    );
        case (op)
            isaPkg::OP_ADD: return a + b;
            isaPkg::OP_SUB: return a - b;
            isaPkg::OP_AND: return a & b;
            isaPkg::OP_OR:  return a | b;
            default:        return a ^ b;
        endcase
    endfunction

    task automatic checkWord(input string name, input isaPkg::wordT exp,
                             input isaPkg::wordT got);
        if (got !== exp) begin
            valueErrors++;
            $display("[FAIL] %s expected %08h got %08h", name, exp, got);
        end
    endtask

    task automatic checkBusy(input string name, input bit exp, input logic got);
        if (got !== exp) begin
            valueErrors++;
            $display("[FAIL] %s expected %0h got %0h", name, exp, got);
        end
    endtask

    task automatic checkLatency(input int exp, input int got);
        if (got != exp) begin
            valueErrors++;
            $display("[FAIL] done latency expected %0h got %0h", exp, got);
        end
    endtask

    // Called on a falling edge, returns on the falling edge that shows done
    task automatic sendInstr(input isaPkg::instrT ins, input int expLat,
                             output isaPkg::wordT res);
        int cycles;
        bit seen;
        cycles = 0;
        seen = 1'b0;
        res = '0;
        checkBusy("busy", 1'b0, busy);
        instrValid = 1'b1;
        instr = ins;
        while (!seen && cycles < DONE_WAIT) begin
            @(negedge clk);
            cycles++;
            instrValid = 1'b0;
            if (done === 1'b1) begin
                seen = 1'b1;
                res = result;
                // busy falls together with done
                checkBusy("busy", 1'b0, busy);
            end else begin
                checkBusy("busy", 1'b1, busy);
            end
        end
        if (!seen) begin
            protocolErrors++;
            $display("sendInstr: done did not arrive within %0d cycles", DONE_WAIT);
        end else begin
            checkLatency(expLat, cycles);
        end
    endtask

    // Observation port is combinational, sampled shortly after the address
    task automatic readReg(input isaPkg::regIdxT idx, output isaPkg::wordT val);
        readAddr = idx;
        #1;
        val = readData;
        @(negedge clk);
    endtask

    task automatic checkReg(input isaPkg::regIdxT idx);
        isaPkg::wordT got;
        readReg(idx, got);
        checkWord($sformatf("r%0d", idx), model[idx], got);
    endtask

    task automatic loadImm(input isaPkg::regIdxT rd, input isaPkg::immT imm);
        isaPkg::wordT res;
        sendInstr(makeInstr(isaPkg::OP_LDI, rd, '0, '0, imm), PLAIN_LAT, res);
        model[rd] = isaPkg::wordT'(imm);
        checkWord("result", model[rd], res);
    endtask

    task automatic runOp(input isaPkg::opT op, input isaPkg::regIdxT rd,
                         input isaPkg::regIdxT rs1, input isaPkg::regIdxT rs2);
        isaPkg::wordT exp;
        isaPkg::wordT res;
        exp = expectedAlu(op, model[rs1], model[rs2]);
        sendInstr(makeInstr(op, rd, rs1, rs2, '0), PLAIN_LAT, res);
        model[rd] = exp;
        checkWord("result", exp, res);
        checkReg(rd);
    endtask

    // rd = 4 * rs1, result only
    task automatic runQuad(input isaPkg::regIdxT rd, input isaPkg::regIdxT rs1);
        isaPkg::wordT exp;
        isaPkg::wordT res;
        exp = model[rs1] * 4;
        sendInstr(makeInstr(isaPkg::OP_MQUAD, rd, rs1, '0, '0), QUAD_LAT, res);
        model[rd] = exp;
        checkWord("result", exp, res);
    endtask

    // rd = rs1 + 2 * rs2, result only
    task automatic runTri(input isaPkg::regIdxT rd, input isaPkg::regIdxT rs1,
                          input isaPkg::regIdxT rs2);
        isaPkg::wordT exp;
        isaPkg::wordT res;
        exp = model[rs1] + model[rs2] * 2;
        sendInstr(makeInstr(isaPkg::OP_MTRI, rd, rs1, rs2, '0), TRI_LAT, res);
        model[rd] = exp;
        checkWord("result", exp, res);
    endtask

    task automatic resetState();
        checkBusy("busy", 1'b0, busy);
        checkBusy("done", 1'b0, done);
        for (int i = 0; i < isaPkg::NUM_REGS; i++) begin
            checkReg(isaPkg::regIdxT'(i));
        end
    endtask

    task automatic plainOps();
        isaPkg::opT     aluOps [5];
        isaPkg::regIdxT ra;
        isaPkg::regIdxT rb;
        logic [31:0]    r;
        aluOps[0] = isaPkg::OP_ADD;
        aluOps[1] = isaPkg::OP_SUB;
        aluOps[2] = isaPkg::OP_AND;
        aluOps[3] = isaPkg::OP_OR;
        aluOps[4] = isaPkg::OP_XOR;
        repeat (6) begin
            ra = pickReg();
            rb = pickReg();
            r = nextRand();
            loadImm(ra, r[15:0]);
            loadImm(rb, r[31:16]);
            // Results feed later rounds, so operands grow past 16 bits
            for (int k = 0; k < 5; k++) begin
                runOp(aluOps[k], pickReg(), ra, rb);
            end
        end
    endtask

    task automatic quadMacro();
        isaPkg::regIdxT rd;
        repeat (3) begin
            rd = pickReg();
            runQuad(rd, pickReg());
            checkReg(rd);
        end
    endtask

    task automatic triMacro();
        isaPkg::regIdxT rd;
        repeat (3) begin
            rd = pickReg();
            runTri(rd, pickReg(), pickReg());
            checkReg(rd);
        end
    endtask

    // Macros must leave every other main register alone
    task automatic shadowIsolation();
        logic [31:0] r;
        loadImm(isaPkg::SCRATCH_REG, 16'hA5C3);
        for (int i = 0; i < 15; i++) begin
            r = nextRand();
            loadImm(isaPkg::regIdxT'(i), r[15:0]);
        end
        runQuad(4'd2, 4'd5);
        runTri(4'd7, 4'd1, 4'd9);
        for (int i = 0; i < isaPkg::NUM_REGS; i++) begin
            checkReg(isaPkg::regIdxT'(i));
        end
    endtask

    // Plain op issued on the same falling edge that shows the macro's done
    task automatic backToBack();
        runQuad(4'd3, 4'd4);
        runOp(isaPkg::OP_ADD, 4'd6, 4'd3, 4'd8);
        checkReg(4'd3);
    endtask

    initial begin
        rst = 1'b1;
        instrValid = 1'b0;
        instr = '0;
        readAddr = '0;
        rngState = 32'hcbe6643d;
        for (int i = 0; i < isaPkg::NUM_REGS; i++) begin
            model[i] = '0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;

        resetState();
        plainOps();
        quadMacro();
        triMacro();
        shadowIsolation();
        backToBack();

        $display("Errors: value %0d, protocol %0d", valueErrors, protocolErrors);
        if (valueErrors == 0 && protocolErrors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* execCore.f */
isaPkg.sv
ucodePkg.sv
regFile.sv
alu.sv
ucodeRom.sv
coreCtrl.sv
execCore.sv
tbExecCore.sv
